// ==== hw/pipeline_pkg.sv ====
// shared instruction format, opcode and error encodings and vector types; compile before the RTL
package pipeline_pkg;

	//////////////////////////////////////////////////////////////////////
	// vector types
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] inst_t;     // one instruction word
	typedef logic [4:0]  reg_idx_t;  // architectural register index
	typedef logic [3:0]  opcode_t;
	typedef logic [1:0]  error_t;    // bundle-level status

	localparam int NUM_REGS  = 32;
	localparam int IMM_WIDTH = 13;

	localparam reg_idx_t ZERO_REG = 5'd0; // hardwired zero

	// instruction fields, lsb of each
	// opcode 31:28, rd 27:23, rs1 22:18, rs2 17:13, imm 12:0
	localparam int OPCODE_LSB = 28;
	localparam int RD_LSB     = 23;
	localparam int RS1_LSB    = 18;
	localparam int RS2_LSB    = 13;
	localparam int IMM_LSB    = 0;

	//////////////////////////////////////////////////////////////////////
	// opcodes
	//////////////////////////////////////////////////////////////////////

	localparam opcode_t OP_NOP  = 4'h0;
	localparam opcode_t OP_ADD  = 4'h1;
	localparam opcode_t OP_SUB  = 4'h2;
	localparam opcode_t OP_AND  = 4'h3;
	localparam opcode_t OP_OR   = 4'h4;
	localparam opcode_t OP_XOR  = 4'h5;
	localparam opcode_t OP_SLT  = 4'h6; // signed compare
	localparam opcode_t OP_ADDI = 4'h7; // rs1 + sign-extended imm
	localparam opcode_t OP_HALT = 4'h8;
	// 4'h9 and up are illegal

	//////////////////////////////////////////////////////////////////////
	// error status, illegal outranks halted
	//////////////////////////////////////////////////////////////////////

	localparam error_t ERR_NONE    = 2'd0;
	localparam error_t ERR_HALTED  = 2'd1;
	localparam error_t ERR_ILLEGAL = 2'd2;

endpackage

// ==== hw/issue_decode.sv ====
// input side of the pipeline: captures a strobed bundle, decodes each way and registers it for execute
module issue_decode #(
	parameter int WAYS = 3,
	parameter int XLEN = 32
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  bundle_valid,               // one-cycle strobe
	input  pipeline_pkg::inst_t   bundle_inst [WAYS],
	// register file read ports
	output pipeline_pkg::reg_idx_t rd_idx_a   [WAYS],
	output pipeline_pkg::reg_idx_t rd_idx_b   [WAYS],
	input  logic [XLEN-1:0]        rd_data_a  [WAYS],
	input  logic [XLEN-1:0]        rd_data_b  [WAYS],
	// decode-to-execute register
	output logic                   dx_valid,
	output pipeline_pkg::opcode_t  dx_opcode  [WAYS],
	output pipeline_pkg::reg_idx_t dx_rd      [WAYS],
	output pipeline_pkg::reg_idx_t dx_rs1     [WAYS],
	output pipeline_pkg::reg_idx_t dx_rs2     [WAYS],
	output logic [XLEN-1:0]        dx_imm     [WAYS],
	output logic [XLEN-1:0]        dx_op_a    [WAYS],
	output logic [XLEN-1:0]        dx_op_b    [WAYS],
	output logic                   dx_wr_en   [WAYS],
	output logic                   dx_illegal [WAYS]
);

	pipeline_pkg::opcode_t  dec_opcode  [WAYS];
	pipeline_pkg::reg_idx_t dec_rd      [WAYS];
	logic [XLEN-1:0]        dec_imm     [WAYS];
	logic                   dec_wr_en   [WAYS];
	logic                   dec_illegal [WAYS];

	//////////////////////////////////////////////////////////////////////
	// field split and opcode classification
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		pipeline_pkg::inst_t inst;
		logic                writes;
		for (int w = 0; w < WAYS; w++) begin
			inst          = bundle_inst[w];
			writes        = 1'b0;
			dec_illegal[w] = 1'b0;
			dec_opcode[w] = inst[pipeline_pkg::OPCODE_LSB +: 4];
			dec_rd[w]     = inst[pipeline_pkg::RD_LSB +: 5];
			rd_idx_a[w]   = inst[pipeline_pkg::RS1_LSB +: 5]; // straight to the register file
			rd_idx_b[w]   = inst[pipeline_pkg::RS2_LSB +: 5];
			dec_imm[w]    = {{(XLEN - pipeline_pkg::IMM_WIDTH){inst[pipeline_pkg::IMM_WIDTH - 1]}},
				inst[pipeline_pkg::IMM_LSB +: pipeline_pkg::IMM_WIDTH]};

			case (dec_opcode[w])
				pipeline_pkg::OP_ADD,
				pipeline_pkg::OP_SUB,
				pipeline_pkg::OP_AND,
				pipeline_pkg::OP_OR,
				pipeline_pkg::OP_XOR,
				pipeline_pkg::OP_SLT,
				pipeline_pkg::OP_ADDI: writes = 1'b1;
				pipeline_pkg::OP_NOP,
				pipeline_pkg::OP_HALT: writes = 1'b0;
				default:               dec_illegal[w] = 1'b1;
			endcase

			// only place the write decision is made
			dec_wr_en[w] = writes && (dec_rd[w] != pipeline_pkg::ZERO_REG);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// decode-to-execute register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!reset) begin
			dx_valid <= 1'b0;
			for (int w = 0; w < WAYS; w++) begin
				dx_wr_en[w]   <= 1'b0;
				dx_illegal[w] <= 1'b0;
			end
		end else begin
			dx_valid <= bundle_valid; // bubble when no strobe
			for (int w = 0; w < WAYS; w++) begin
				dx_wr_en[w]   <= dec_wr_en[w];
				dx_illegal[w] <= dec_illegal[w];
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			dx_opcode[w] <= dec_opcode[w];
			dx_rd[w]     <= dec_rd[w];
			dx_rs1[w]    <= rd_idx_a[w];
			dx_rs2[w]    <= rd_idx_b[w];
			dx_imm[w]    <= dec_imm[w];
			dx_op_a[w]   <= rd_data_a[w];
			dx_op_b[w]   <= rd_data_b[w];
		end
	end

endmodule

// ==== hw/register_file.sv ====
// shared register file with two read ports and one write port per way, read by decode, written by writeback
module register_file #(
	parameter int WAYS = 3,
	parameter int XLEN = 32
) (
	input  logic                   clock,
	input  logic                   reset,
	input  pipeline_pkg::reg_idx_t rd_idx_a  [WAYS],
	input  pipeline_pkg::reg_idx_t rd_idx_b  [WAYS],
	output logic [XLEN-1:0]        rd_data_a [WAYS],
	output logic [XLEN-1:0]        rd_data_b [WAYS],
	input  logic                   wr_en     [WAYS],
	input  pipeline_pkg::reg_idx_t wr_idx    [WAYS],
	input  logic [XLEN-1:0]        wr_data   [WAYS]
);

	logic [XLEN-1:0] regs [pipeline_pkg::NUM_REGS];

	// writes land in way order so the highest way overrides
	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < pipeline_pkg::NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (wr_en[w] && wr_idx[w] != pipeline_pkg::ZERO_REG) begin
					regs[wr_idx[w]] <= wr_data[w];
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read ports with write-through bypass
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int r = 0; r < WAYS; r++) begin
			rd_data_a[r] = regs[rd_idx_a[r]];
			rd_data_b[r] = regs[rd_idx_b[r]];
			// later ways checked last, same priority as the write
			for (int w = 0; w < WAYS; w++) begin
				if (wr_en[w] && wr_idx[w] == rd_idx_a[r]) rd_data_a[r] = wr_data[w];
				if (wr_en[w] && wr_idx[w] == rd_idx_b[r]) rd_data_b[r] = wr_data[w];
			end
			if (rd_idx_a[r] == pipeline_pkg::ZERO_REG) rd_data_a[r] = '0;
			if (rd_idx_b[r] == pipeline_pkg::ZERO_REG) rd_data_b[r] = '0;
		end
	end

endmodule

// ==== hw/execute_stage.sv ====
// execute stage: one ALU per way with forwarding from the bundle in writeback, then the execute-to-writeback register
module execute_stage #(
	parameter int WAYS = 3,
	parameter int XLEN = 32
) (
	input  logic                   clock,
	input  logic                   reset,
	// decode-to-execute register
	input  logic                   dx_valid,
	input  pipeline_pkg::opcode_t  dx_opcode  [WAYS],
	input  pipeline_pkg::reg_idx_t dx_rd      [WAYS],
	input  pipeline_pkg::reg_idx_t dx_rs1     [WAYS],
	input  pipeline_pkg::reg_idx_t dx_rs2     [WAYS],
	input  logic [XLEN-1:0]        dx_imm     [WAYS],
	input  logic [XLEN-1:0]        dx_op_a    [WAYS],
	input  logic [XLEN-1:0]        dx_op_b    [WAYS],
	input  logic                   dx_wr_en   [WAYS],
	input  logic                   dx_illegal [WAYS],
	// bundle currently committing
	input  logic                   fwd_wr_en  [WAYS],
	input  pipeline_pkg::reg_idx_t fwd_rd     [WAYS],
	input  logic [XLEN-1:0]        fwd_result [WAYS],
	// execute-to-writeback register
	output logic                   xw_valid,
	output logic                   xw_wr_en   [WAYS],
	output pipeline_pkg::reg_idx_t xw_rd      [WAYS],
	output logic [XLEN-1:0]        xw_result  [WAYS],
	output logic                   xw_halt    [WAYS],
	output logic                   xw_illegal [WAYS]
);

	always_ff @(posedge clock) begin
		if (!reset) xw_valid <= 1'b0;
		else        xw_valid <= dx_valid;
	end

	for (genvar g = 0; g < WAYS; g++) begin : g_way
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
		logic [XLEN-1:0] result;

		//////////////////////////////////////////////////////////////////
		// forwarding, highest matching way wins
		//////////////////////////////////////////////////////////////////

		always_comb begin
			op_a = dx_op_a[g];
			op_b = dx_op_b[g];
			for (int f = 0; f < WAYS; f++) begin
				// fwd_wr_en never set for r0
				if (fwd_wr_en[f] && fwd_rd[f] == dx_rs1[g]) op_a = fwd_result[f];
				if (fwd_wr_en[f] && fwd_rd[f] == dx_rs2[g]) op_b = fwd_result[f];
			end
		end

		// alu
		always_comb begin
			case (dx_opcode[g])
				pipeline_pkg::OP_ADD:  result = op_a + op_b;
				pipeline_pkg::OP_SUB:  result = op_a - op_b;
				pipeline_pkg::OP_AND:  result = op_a & op_b;
				pipeline_pkg::OP_OR:   result = op_a | op_b;
				pipeline_pkg::OP_XOR:  result = op_a ^ op_b;
				pipeline_pkg::OP_SLT:  result = {{(XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
				pipeline_pkg::OP_ADDI: result = op_a + dx_imm[g];
				default:               result = '0; // nop, halt, illegal
			endcase
		end

		always_ff @(posedge clock) begin
			if (!reset) begin
				xw_wr_en[g]   <= 1'b0;
				xw_halt[g]    <= 1'b0;
				xw_illegal[g] <= 1'b0;
			end else begin
				xw_wr_en[g]   <= dx_wr_en[g];
				xw_halt[g]    <= dx_opcode[g] == pipeline_pkg::OP_HALT;
				xw_illegal[g] <= dx_illegal[g];
			end
		end

		always_ff @(posedge clock) begin
			xw_rd[g]     <= dx_rd[g];
			xw_result[g] <= result;
		end
	end

endmodule

// ==== hw/writeback_stage.sv ====
// writeback: drives the commit ports, the bundle error status and the register file writes
module writeback_stage #(
	parameter int WAYS = 3,
	parameter int XLEN = 32
) (
	input  logic                   xw_valid,
	input  logic                   xw_wr_en       [WAYS],
	input  pipeline_pkg::reg_idx_t xw_rd          [WAYS],
	input  logic [XLEN-1:0]        xw_result      [WAYS],
	input  logic                   xw_halt        [WAYS],
	input  logic                   xw_illegal     [WAYS],
	// commit ports
	output logic                   commit_valid,
	output logic                   commit_wr_en   [WAYS],
	output pipeline_pkg::reg_idx_t commit_wr_idx  [WAYS],
	output logic [XLEN-1:0]        commit_wr_data [WAYS],
	output pipeline_pkg::error_t   error_status,
	// back to the register file and forwarding
	output logic                   rf_wr_en       [WAYS],
	output pipeline_pkg::reg_idx_t rf_wr_idx      [WAYS],
	output logic [XLEN-1:0]        rf_wr_data     [WAYS]
);

	logic any_halt;
	logic any_illegal;

	assign commit_valid = xw_valid;

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			rf_wr_en[w]   = xw_valid && xw_wr_en[w]; // bubbles write nothing
			rf_wr_idx[w]  = xw_rd[w];
			rf_wr_data[w] = xw_result[w];

			commit_wr_en[w]   = rf_wr_en[w];
			commit_wr_idx[w]  = xw_rd[w];
			commit_wr_data[w] = xw_result[w];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// error status
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		any_halt    = 1'b0;
		any_illegal = 1'b0;
		for (int w = 0; w < WAYS; w++) begin
			any_halt    = any_halt | xw_halt[w];
			any_illegal = any_illegal | xw_illegal[w];
		end
	end

	// illegal first, then halt
	always_comb begin
		if (!xw_valid)        error_status = pipeline_pkg::ERR_NONE;
		else if (any_illegal) error_status = pipeline_pkg::ERR_ILLEGAL;
		else if (any_halt)    error_status = pipeline_pkg::ERR_HALTED;
		else                  error_status = pipeline_pkg::ERR_NONE;
	end

endmodule

// ==== hw/superscalar_pipeline.sv ====
// top level of the superscalar pipeline; sets WAYS and XLEN and wires the stages to the register file
module superscalar_pipeline #(
	parameter int WAYS = 3,
	parameter int XLEN = 32
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   bundle_valid,
	input  pipeline_pkg::inst_t    bundle_inst    [WAYS],
	output logic                   commit_valid,
	output logic                   commit_wr_en   [WAYS],
	output pipeline_pkg::reg_idx_t commit_wr_idx  [WAYS],
	output logic [XLEN-1:0]        commit_wr_data [WAYS],
	output pipeline_pkg::error_t   error_status
);

	// register file read side
	pipeline_pkg::reg_idx_t rd_idx_a [WAYS];
	pipeline_pkg::reg_idx_t rd_idx_b [WAYS];
	logic [XLEN-1:0]        rd_data_a [WAYS];
	logic [XLEN-1:0]        rd_data_b [WAYS];

	// decode to execute
	logic                   dx_valid;
	pipeline_pkg::opcode_t  dx_opcode  [WAYS];
	pipeline_pkg::reg_idx_t dx_rd      [WAYS];
	pipeline_pkg::reg_idx_t dx_rs1     [WAYS];
	pipeline_pkg::reg_idx_t dx_rs2     [WAYS];
	logic [XLEN-1:0]        dx_imm     [WAYS];
	logic [XLEN-1:0]        dx_op_a    [WAYS];
	logic [XLEN-1:0]        dx_op_b    [WAYS];
	logic                   dx_wr_en   [WAYS];
	logic                   dx_illegal [WAYS];

	// execute to writeback
	logic                   xw_valid;
	logic                   xw_wr_en   [WAYS];
	pipeline_pkg::reg_idx_t xw_rd      [WAYS];
	logic [XLEN-1:0]        xw_result  [WAYS];
	logic                   xw_halt    [WAYS];
	logic                   xw_illegal [WAYS];

	// writeback results, also the forwarding source
	logic                   rf_wr_en   [WAYS];
	pipeline_pkg::reg_idx_t rf_wr_idx  [WAYS];
	logic [XLEN-1:0]        rf_wr_data [WAYS];

	issue_decode #(.WAYS(WAYS), .XLEN(XLEN)) issue_decode_0 (
		.clock, .reset, .bundle_valid, .bundle_inst,
		.rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
		.dx_valid, .dx_opcode, .dx_rd, .dx_rs1, .dx_rs2, .dx_imm,
		.dx_op_a, .dx_op_b, .dx_wr_en, .dx_illegal
	);

	register_file #(.WAYS(WAYS), .XLEN(XLEN)) register_file_0 (
		.clock, .reset, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
		.wr_en(rf_wr_en), .wr_idx(rf_wr_idx), .wr_data(rf_wr_data)
	);

	execute_stage #(.WAYS(WAYS), .XLEN(XLEN)) execute_stage_0 (
		.clock, .reset,
		.dx_valid, .dx_opcode, .dx_rd, .dx_rs1, .dx_rs2, .dx_imm,
		.dx_op_a, .dx_op_b, .dx_wr_en, .dx_illegal,
		.fwd_wr_en(rf_wr_en), .fwd_rd(rf_wr_idx), .fwd_result(rf_wr_data),
		.xw_valid, .xw_wr_en, .xw_rd, .xw_result, .xw_halt, .xw_illegal
	);

	writeback_stage #(.WAYS(WAYS), .XLEN(XLEN)) writeback_stage_0 (
		.xw_valid, .xw_wr_en, .xw_rd, .xw_result, .xw_halt, .xw_illegal,
		.commit_valid, .commit_wr_en, .commit_wr_idx, .commit_wr_data, .error_status,
		.rf_wr_en, .rf_wr_idx, .rf_wr_data
	);

endmodule

// ==== testbench/pipeline_model.svh ====
// reference model included inside the pipeline testbench; tracks architectural registers and predicts commits
`ifndef PIPELINE_MODEL_SVH
`define PIPELINE_MODEL_SVH

typedef struct packed {
	int                        due;     // cycle count when the commit should show
	int                        test_id;
	logic [1:0]                err;
	logic [WAYS-1:0]           wr_en;
	logic [WAYS-1:0][4:0]      idx;
	logic [WAYS-1:0][XLEN-1:0] data;
} commit_t;

logic [XLEN-1:0] model_regs [32];
commit_t         expected_q [$];

task automatic reset_model();
	for (int r = 0; r < 32; r++) model_regs[r] = '0;
	expected_q.delete();
endtask

function automatic logic [XLEN-1:0] read_model(input logic [4:0] idx);
	if (idx == 5'd0) return '0; // r0 always reads zero
	return model_regs[idx];
endfunction

// opcodes that produce a register result
function automatic logic writes_result(input logic [3:0] op);
	case (op)
		pipeline_pkg::OP_ADD, pipeline_pkg::OP_SUB, pipeline_pkg::OP_AND, pipeline_pkg::OP_OR,
		pipeline_pkg::OP_XOR, pipeline_pkg::OP_SLT, pipeline_pkg::OP_ADDI: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [XLEN-1:0] alu_model(input logic [3:0] op, input logic [XLEN-1:0] a,
	input logic [XLEN-1:0] b, input logic [12:0] imm);
	logic [XLEN-1:0] simm;
	simm = {{(XLEN - 13){imm[12]}}, imm};
	case (op)
		pipeline_pkg::OP_ADD:  return a + b;
		pipeline_pkg::OP_SUB:  return a - b;
		pipeline_pkg::OP_AND:  return a & b;
		pipeline_pkg::OP_OR:   return a | b;
		pipeline_pkg::OP_XOR:  return a ^ b;
		pipeline_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
		pipeline_pkg::OP_ADDI: return a + simm;
		default:               return '0;
	endcase
endfunction

// every way reads the state before the bundle, writes then land in way order
task automatic predict_bundle(input logic [WAYS-1:0][31:0] insts, input int test_id,
	input int due);
	commit_t    exp;
	logic [3:0] op;
	logic       any_illegal;
	logic       any_halt;
	exp = '0;
	exp.due = due;
	exp.test_id = test_id;
	any_illegal = 1'b0;
	any_halt = 1'b0;
	for (int w = 0; w < WAYS; w++) begin
		op = insts[w][31:28];
		exp.idx[w] = insts[w][27:23];
		exp.wr_en[w] = writes_result(op) && exp.idx[w] != 5'd0;
		exp.data[w] = alu_model(op, read_model(insts[w][22:18]), read_model(insts[w][17:13]),
			insts[w][12:0]);
		if (op == pipeline_pkg::OP_HALT) any_halt = 1'b1;
		else if (op != pipeline_pkg::OP_NOP && !writes_result(op)) any_illegal = 1'b1;
	end
	if (any_illegal) exp.err = pipeline_pkg::ERR_ILLEGAL;
	else if (any_halt) exp.err = pipeline_pkg::ERR_HALTED;
	else exp.err = pipeline_pkg::ERR_NONE;
	for (int w = 0; w < WAYS; w++) begin
		if (exp.wr_en[w]) model_regs[exp.idx[w]] = exp.data[w]; // highest way lands last
	end
	expected_q.push_back(exp);
endtask

`endif

// ==== testbench/pipeline_tb.sv ====
// testbench that checks seeded random superscalar pipeline bundles against a reference model
module pipeline_tb;

	localparam int WAYS = 3;
	localparam int XLEN = 32;

	localparam int RESET_CYCLES   = 4;
	localparam int IDLE_CYCLES    = 6;
	localparam int RANDOM_BUNDLES = 200;
	localparam int CHAIN_BUNDLES  = 48;
	localparam int SAME_ROUNDS    = 6;  // up to 3 cycles each
	localparam int ERROR_BUNDLES  = 60;
	localparam int ZERO_BUNDLES   = 30;
	localparam int NUM_TESTS      = 6;
	localparam int CYCLE_LIMIT    = RESET_CYCLES + IDLE_CYCLES + RANDOM_BUNDLES + CHAIN_BUNDLES
		+ 3 * SAME_ROUNDS + ERROR_BUNDLES + ZERO_BUNDLES + 4 * NUM_TESTS + 20;

	logic                   clock;
	logic                   reset;
	logic                   bundle_valid;
	pipeline_pkg::inst_t    bundle_inst    [WAYS];
	logic                   commit_valid;
	logic                   commit_wr_en   [WAYS];
	pipeline_pkg::reg_idx_t commit_wr_idx  [WAYS];
	logic [XLEN-1:0]        commit_wr_data [WAYS];
	pipeline_pkg::error_t   error_status;

	integer seed;
	int     cycle_count = 0;
	int     error_count = 0;
	int     check_count = 0;
	int     failed_tests = 0;
	string  test_names [NUM_TESTS];

	`include "pipeline_model.svh"

	superscalar_pipeline #(.WAYS(WAYS), .XLEN(XLEN)) uut (
		.clock, .reset, .bundle_valid, .bundle_inst,
		.commit_valid, .commit_wr_en, .commit_wr_idx, .commit_wr_data, .error_status
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) cycle_count <= cycle_count + 1;

	initial begin
		while (cycle_count < CYCLE_LIMIT) @(posedge clock);
		$display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] make_inst(input logic [3:0] op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2, input logic [12:0] imm);
		return {op, rd, rs1, rs2, imm};
	endfunction

	// mostly r1 to r4 so hazards come up often
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $random(seed);
		if (r[2:0] != 3'd0) return 5'd1 + r[4:3];
		return r[9:5];
	endfunction

	function automatic logic [31:0] random_inst();
		logic [31:0] r;
		logic [3:0]  op;
		r = $random(seed);
		op = {1'b0, r[15:13]}; // nop through addi, legal ops only
		return make_inst(op, pick_reg(), pick_reg(), pick_reg(), r[12:0]);
	endfunction

	task automatic idle_cycle();
		@(posedge clock);
		bundle_valid <= 1'b0;
	endtask

	task automatic issue_bundle(input logic [WAYS-1:0][31:0] insts, input int test_id);
		@(posedge clock);
		bundle_valid <= 1'b1;
		for (int w = 0; w < WAYS; w++) bundle_inst[w] <= insts[w];
		predict_bundle(insts, test_id, cycle_count + 3); // counter still holds the last edge
	endtask

	task automatic finish_test(input int test_id, input int errors_before);
		while (expected_q.size() != 0) idle_cycle();
		if (error_count == errors_before) begin
			$display("test %s: ok", test_names[test_id]);
		end else begin
			failed_tests++;
			$display("test %s: %0d errors", test_names[test_id], error_count - errors_before);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// commit checks on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string test, input string what,
		input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
		$display("Mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
		error_count++;
	endtask

	task automatic check_commit();
		commit_t exp;
		string   name;
		if (expected_q.size() != 0 && expected_q[0].due == cycle_count) begin
			exp = expected_q.pop_front();
			name = test_names[exp.test_id];
			check_count++;
			if (commit_valid !== 1'b1) begin
				$display("Error: %s bundle did not commit at cycle %0d", name, cycle_count);
				error_count++;
			end else begin
				if (error_status !== exp.err)
					report_mismatch(name, "error_status", exp.err, error_status);
				for (int w = 0; w < WAYS; w++) begin
					if (commit_wr_en[w] !== exp.wr_en[w])
						report_mismatch(name, $sformatf("way %0d wr_en", w),
							exp.wr_en[w], commit_wr_en[w]);
					else if (exp.wr_en[w] && commit_wr_idx[w] !== exp.idx[w])
						report_mismatch(name, $sformatf("way %0d idx", w),
							exp.idx[w], commit_wr_idx[w]);
					else if (exp.wr_en[w] && commit_wr_data[w] !== exp.data[w])
						report_mismatch(name, $sformatf("way %0d data", w),
							exp.data[w], commit_wr_data[w]);
				end
			end
		end else begin
			if (commit_valid !== 1'b0 || error_status !== pipeline_pkg::ERR_NONE) begin
				$display("Error: commit outputs active with no bundle due at cycle %0d",
					cycle_count);
				error_count++;
			end
			for (int w = 0; w < WAYS; w++) begin
				if (commit_wr_en[w] !== 1'b0) begin
					$display("Error: commit_wr_en of way %0d high outside a commit", w);
					error_count++;
				end
			end
		end
	endtask

	always @(negedge clock) begin
		if (reset) check_commit();
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [WAYS-1:0][31:0] insts;
		logic [31:0]           r;
		logic [4:0]            rt;
		int                    start;
		test_names = '{"reset_idle", "random_back_to_back", "dependent_chain",
			"same_register_writes", "error_status", "zero_register"};
		seed = 32'h5880b5a2;
		reset = 1'b0;
		bundle_valid = 1'b0;
		for (int w = 0; w < WAYS; w++) bundle_inst[w] = '0;
		reset_model();
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b1;

		start = error_count;
		repeat (IDLE_CYCLES) idle_cycle();
		finish_test(0, start);

		start = error_count;
		repeat (RANDOM_BUNDLES) begin
			for (int w = 0; w < WAYS; w++) insts[w] = random_inst();
			issue_bundle(insts, 1);
		end
		finish_test(1, start);

		// three registers only, so each bundle reads the last two
		start = error_count;
		repeat (CHAIN_BUNDLES) begin
			for (int w = 0; w < WAYS; w++) begin
				r = $random(seed);
				insts[w] = random_inst();
				insts[w][27:23] = 5'd1 + r[1:0] % 3;
				insts[w][22:18] = 5'd1 + r[3:2] % 3;
				insts[w][17:13] = 5'd1 + r[5:4] % 3;
			end
			issue_bundle(insts, 2);
		end
		finish_test(2, start);

		// odd rounds leave a gap so the reader goes through the register file
		start = error_count;
		for (int n = 0; n < SAME_ROUNDS; n++) begin
			rt = 5'd8 + n;
			for (int w = 0; w < WAYS; w++) begin
				r = 16 * n + w + 1;
				insts[w] = make_inst(pipeline_pkg::OP_ADDI, rt, rt, 5'd0, r[12:0]);
			end
			issue_bundle(insts, 3);
			if (n % 2 == 1) idle_cycle();
			for (int w = 0; w < WAYS; w++)
				insts[w] = make_inst(pipeline_pkg::OP_ADDI, 5'd16 + w, rt, 5'd0, 13'd0);
			issue_bundle(insts, 3);
		end
		finish_test(3, start);

		start = error_count;
		repeat (ERROR_BUNDLES) begin
			for (int w = 0; w < WAYS; w++) begin
				r = $random(seed);
				insts[w] = random_inst();
				if (r[2:0] == 3'd0) insts[w][31:28] = pipeline_pkg::OP_HALT;
				else if (r[2:0] == 3'd1) insts[w][31:28] = 4'h9 + r[5:3] % 7; // illegal range
			end
			issue_bundle(insts, 4);
		end
		finish_test(4, start);

		start = error_count;
		repeat (ZERO_BUNDLES) begin
			for (int w = 0; w < WAYS; w++) begin
				r = $random(seed);
				insts[w] = random_inst();
				if (r[0]) insts[w][27:23] = 5'd0;
				if (r[1]) insts[w][22:18] = 5'd0;
				if (r[2]) insts[w][17:13] = 5'd0;
			end
			issue_bundle(insts, 5);
		end
		finish_test(5, start);

		$display("%0d tests, %0d failed, %0d commits checked, %0d errors",
			NUM_TESTS, failed_tests, check_count, error_count);
		if (error_count == 0) $display("Simulation PASSED");
		else $display("Simulation FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+testbench
hw/pipeline_pkg.sv
hw/issue_decode.sv
hw/register_file.sv
hw/execute_stage.sv
hw/writeback_stage.sv
hw/superscalar_pipeline.sv
testbench/pipeline_tb.sv
